/* isaPkg.sv */
package isaPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // basic widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [15:0] word_t;   // data word and instruction word.
    typedef logic [2:0]  regIdx_t; // one of eight registers.
    typedef logic [4:0]  imm_t;    // signed immediate, extended in decode.

    // instruction field positions, counted from the lsb of each field.
    localparam int OPC_LSB = 11;
    localparam int RS_LSB  = 8;
    localparam int RT_LSB  = 5;  // also the destination of ADDI and LD.
    localparam int RD_LSB  = 2;  // destination of R-type.
    localparam int IMM_LSB = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes. anything not listed here runs as a no-op.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [4:0] {
        OP_ADD  = 5'b11000,
        OP_SUB  = 5'b11001,
        OP_AND  = 5'b11010,
        OP_XOR  = 5'b11011,
        OP_ADDI = 5'b01000,
        OP_LD   = 5'b10001,
        OP_ST   = 5'b10000
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR,
        ALU_PASS // hands opB through.
    } aluOp_t;

endpackage

/* pipePkg.sv */
package pipePkg;
    import isaPkg::*;

    localparam int MEM_ADDR_W = 4; // data memory is 2**MEM_ADDR_W words.

    typedef logic [MEM_ADDR_W-1:0] dataAddr_t;

    // one entry of the hazard unit's shadow pipeline.
    typedef struct packed {
        logic      valid;
        logic      writesReg;
        regIdx_t   rd;
        logic      isStore;
        dataAddr_t addr;
    } hazRec_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage records, in pipeline order.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic      valid;
        logic      writesReg;
        logic      isLoad;
        logic      isStore;
        regIdx_t   rd;
        aluOp_t    aluOp;
        word_t     opA;
        word_t     opB;
        word_t     storeData;
        dataAddr_t addr;
    } idRec_t;

    typedef struct packed {
        logic      valid;
        logic      writesReg;
        logic      isLoad;
        logic      isStore;
        regIdx_t   rd;
        word_t     result;
        word_t     storeData;
        dataAddr_t addr;
    } exRec_t;

    typedef struct packed {
        logic      valid;
        logic      writesReg;
        logic      isStore; // the store itself happens while in WB.
        regIdx_t   rd;
        word_t     value;
        word_t     storeData;
        dataAddr_t addr;
    } wbRec_t;

    typedef struct packed {
        logic    valid;
        regIdx_t rd;
        word_t   value;
    } wbPort_t;

endpackage

/* fetchStage.sv */
`timescale 1ns/1ps

module fetchStage import isaPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  instrReq,
    output logic  instrAck,
    input  word_t instr,
    input  logic  stall,
    output logic  slotValid,
    output word_t slotInstr
);

    typedef enum logic {
        IDLE,
        ACKED
    } rxState_t;

    rxState_t state;
    logic     consumed;
    logic     accept;

    assign consumed = slotValid && !stall; // decode takes the slot this cycle.

    // a new word is taken only once the slot is free or being freed.
    assign accept = (state == IDLE) && instrReq && (!slotValid || consumed);

    assign instrAck = (state == ACKED);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            slotValid <= 1'b0;
        end else begin
            case (state)
                IDLE:    if (accept) state <= ACKED;
                ACKED:   if (!instrReq) state <= IDLE; // source has seen the ack.
                default: state <= IDLE;
            endcase
            if (accept) begin
                slotValid <= 1'b1;
            end else if (consumed) begin
                slotValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) slotInstr <= instr;
    end

endmodule

/* hazardDetect.sv */
`timescale 1ns/1ps

module hazardDetect import isaPkg::*, pipePkg::*; #(
    parameter int MEM_ADDR_W = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      slotValid,
    input  regIdx_t   slotRs,
    input  regIdx_t   slotRt,
    input  logic      slotIsLoad,
    input  dataAddr_t slotAddr,
    input  hazRec_t   slotRec,
    output logic      stall
);

    // shadow entries 0 to 3 track ID, EX, MEM and WB in that order.
    hazRec_t               shadow [4];
    logic [MEM_ADDR_W-1:0] ldAddr;
    logic                  regHaz;
    logic                  memHaz;

    assign ldAddr = slotAddr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shadow pipeline.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                shadow[i].valid <= 1'b0;
            end
        end else begin
            shadow[0] <= (slotValid && !stall) ? slotRec : '0; // bubble while held.
            for (int i = 1; i < 4; i++) begin
                shadow[i] <= shadow[i-1];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RAW checks against every instruction still in flight.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        regHaz = 1'b0;
        memHaz = 1'b0;
        for (int i = 0; i < 4; i++) begin
            // both source fields are checked whatever the opcode.
            if (shadow[i].valid && shadow[i].writesReg &&
                (shadow[i].rd == slotRs || shadow[i].rd == slotRt)) begin
                regHaz = 1'b1;
            end
            if (shadow[i].valid && shadow[i].isStore && shadow[i].addr == ldAddr) begin
                memHaz = 1'b1;
            end
        end
    end

    // without forwarding the slot waits until the producer has left WB.
    assign stall = slotValid && (regHaz || (slotIsLoad && memHaz));

endmodule

/* regFile.sv */
`timescale 1ns/1ps

module regFile import isaPkg::*, pipePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regIdx_t rdIdxA,
    input  regIdx_t rdIdxB,
    output word_t   rdDataA,
    output word_t   rdDataB,
    input  wbRec_t  wb
);

    word_t regs [8];

    // reads see the old contents during a write cycle.
    assign rdDataA = regs[rdIdxA];
    assign rdDataB = regs[rdIdxB];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.writesReg) begin
            regs[wb.rd] <= wb.value; // write lands at the end of WB.
        end
    end

endmodule

/* decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import isaPkg::*, pipePkg::*; #(
    parameter int MEM_ADDR_W = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      slotValid,
    input  word_t     slotInstr,
    input  logic      stall,
    output regIdx_t   rdIdxA,
    output regIdx_t   rdIdxB,
    input  word_t     rdDataA,
    input  word_t     rdDataB,
    output regIdx_t   slotRs,
    output regIdx_t   slotRt,
    output logic      slotIsLoad,
    output dataAddr_t slotAddr,
    output hazRec_t   slotRec,
    output idRec_t    idOut
);

    opcode_t opcode;
    aluOp_t  aluOp;
    logic    writesReg;
    logic    isLoad;
    logic    isStore;
    logic    useImm;
    regIdx_t rd;
    word_t   immExt;
    word_t   addrSum;
    idRec_t  idNext;

    assign opcode = opcode_t'(slotInstr[OPC_LSB +: 5]);
    assign slotRs = slotInstr[RS_LSB +: 3];
    assign slotRt = slotInstr[RT_LSB +: 3];
    assign rdIdxA = slotRs;
    assign rdIdxB = slotRt; // store data also comes from this field.

    assign immExt = {{11{slotInstr[IMM_LSB+4]}}, imm_t'(slotInstr[IMM_LSB +: 5])};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcode decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        aluOp     = ALU_PASS;
        writesReg = 1'b0;
        isLoad    = 1'b0;
        isStore   = 1'b0;
        useImm    = 1'b0;
        rd        = slotInstr[RD_LSB +: 3];
        case (opcode)
            OP_ADD: begin
                aluOp     = ALU_ADD;
                writesReg = 1'b1;
            end
            OP_SUB: begin
                aluOp     = ALU_SUB;
                writesReg = 1'b1;
            end
            OP_AND: begin
                aluOp     = ALU_AND;
                writesReg = 1'b1;
            end
            OP_XOR: begin
                aluOp     = ALU_XOR;
                writesReg = 1'b1;
            end
            OP_ADDI: begin
                aluOp     = ALU_ADD;
                writesReg = 1'b1;
                useImm    = 1'b1;
                rd        = slotRt;
            end
            OP_LD: begin
                writesReg = 1'b1;
                isLoad    = 1'b1;
                useImm    = 1'b1;
                rd        = slotRt;
            end
            OP_ST: begin
                isStore = 1'b1;
                useImm  = 1'b1;
            end
            default: ; // undefined codes go down the pipe without effect.
        endcase
    end

    assign addrSum    = rdDataA + immExt;
    assign slotAddr   = addrSum[MEM_ADDR_W-1:0]; // only the low bits reach the memory.
    assign slotIsLoad = isLoad;

    assign slotRec = '{valid: slotValid, writesReg: writesReg, rd: rd,
                       isStore: isStore, addr: slotAddr};

    always_comb begin
        idNext.valid     = slotValid && !stall;
        idNext.writesReg = writesReg;
        idNext.isLoad    = isLoad;
        idNext.isStore   = isStore;
        idNext.rd        = rd;
        idNext.aluOp     = aluOp;
        idNext.opA       = rdDataA;
        idNext.opB       = useImm ? immExt : rdDataB;
        idNext.storeData = rdDataB;
        idNext.addr      = slotAddr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idOut.valid <= 1'b0;
        end else begin
            idOut <= idNext;
        end
    end

endmodule

/* executeStage.sv */
`timescale 1ns/1ps

module executeStage import isaPkg::*, pipePkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  idRec_t idIn,
    output exRec_t exOut
);

    word_t  aluResult;
    exRec_t exNext;

    // results wrap at 16 bits.
    always_comb begin
        case (idIn.aluOp)
            ALU_ADD: aluResult = idIn.opA + idIn.opB;
            ALU_SUB: aluResult = idIn.opA - idIn.opB;
            ALU_AND: aluResult = idIn.opA & idIn.opB;
            ALU_XOR: aluResult = idIn.opA ^ idIn.opB;
            default: aluResult = idIn.opB;
        endcase
    end

    always_comb begin
        exNext.valid     = idIn.valid;
        exNext.writesReg = idIn.writesReg;
        exNext.isLoad    = idIn.isLoad;
        exNext.isStore   = idIn.isStore;
        exNext.rd        = idIn.rd;
        exNext.result    = aluResult;
        exNext.storeData = idIn.storeData;
        exNext.addr      = idIn.addr; // already formed in decode.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exOut.valid <= 1'b0;
        end else begin
            exOut <= exNext;
        end
    end

endmodule

/* memoryStage.sv */
`timescale 1ns/1ps

module memoryStage import isaPkg::*, pipePkg::*; #(
    parameter int MEM_ADDR_W = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  exRec_t exIn,
    output wbRec_t wbOut
);

    localparam int MemDepth = 2 ** MEM_ADDR_W;

    word_t  mem [MemDepth];
    word_t  loadWord;
    wbRec_t wbNext;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // load path and MEM/WB register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign loadWord = mem[exIn.addr]; // a store in WB is not yet visible here.

    always_comb begin
        wbNext.valid     = exIn.valid;
        wbNext.writesReg = exIn.writesReg;
        wbNext.isStore   = exIn.isStore;
        wbNext.rd        = exIn.rd;
        wbNext.value     = exIn.isLoad ? loadWord : exIn.result;
        wbNext.storeData = exIn.storeData;
        wbNext.addr      = exIn.addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbOut.valid <= 1'b0;
        end else begin
            wbOut <= wbNext;
        end
    end

    // stores commit from the WB record.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MemDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (wbOut.valid && wbOut.isStore) begin
            mem[wbOut.addr] <= wbOut.storeData;
        end
    end

endmodule

/* pipeTop.sv */
`timescale 1ns/1ps

module pipeTop import isaPkg::*, pipePkg::*; #(
    parameter int MEM_ADDR_W = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    instrReq,
    output logic    instrAck,
    input  word_t   instr,
    output wbPort_t wbPort
);

    logic      stall;
    logic      slotValid;
    word_t     slotInstr;
    regIdx_t   rdIdxA;
    regIdx_t   rdIdxB;
    word_t     rdDataA;
    word_t     rdDataB;
    regIdx_t   slotRs;
    regIdx_t   slotRt;
    logic      slotIsLoad;
    dataAddr_t slotAddr;
    hazRec_t   slotRec;
    idRec_t    idRec;
    exRec_t    exRec;
    wbRec_t    wbRec;

    fetchStage uFetch (
        .clk, .rst, .instrReq, .instrAck, .instr, .stall, .slotValid, .slotInstr
    );

    hazardDetect #(.MEM_ADDR_W(MEM_ADDR_W)) uHazard (
        .clk, .rst, .slotValid, .slotRs, .slotRt, .slotIsLoad, .slotAddr, .slotRec, .stall
    );

    regFile uRegs (
        .clk, .rst, .rdIdxA, .rdIdxB, .rdDataA, .rdDataB, .wb(wbRec)
    );

    decodeStage #(.MEM_ADDR_W(MEM_ADDR_W)) uDecode (
        .clk, .rst, .slotValid, .slotInstr, .stall, .rdIdxA, .rdIdxB, .rdDataA, .rdDataB,
        .slotRs, .slotRt, .slotIsLoad, .slotAddr, .slotRec, .idOut(idRec)
    );

    executeStage uExecute (
        .clk, .rst, .idIn(idRec), .exOut(exRec)
    );

    memoryStage #(.MEM_ADDR_W(MEM_ADDR_W)) uMemory (
        .clk, .rst, .exIn(exRec), .wbOut(wbRec)
    );

    // only register writes leave the pipeline.
    assign wbPort.valid = wbRec.valid && wbRec.writesReg;
    assign wbPort.rd    = wbRec.rd;
    assign wbPort.value = wbRec.value;

endmodule

/* tb_pipeTop.sv */
`timescale 1ns/1ps

module tb_pipeTop
    import isaPkg::*, pipePkg::*;
();

    // instruction counts of the five random sequences below.
    localparam int NumInstr       = 40 + 30 + 40 + 20 + 300;
    localparam int WatchdogCycles = 40 * NumInstr + 100;

    logic    clk;
    logic    rst;
    logic    instrReq;
    logic    instrAck;
    word_t   instr;
    wbPort_t wbPort;

    integer  seed;
    word_t   modelRegs [8];
    word_t   modelMem [2 ** MEM_ADDR_W];
    wbPort_t expectedQ [$];
    wbPort_t expEntry;
    int      stallCycles;

    pipeTop #(.MEM_ADDR_W(MEM_ADDR_W)) dut (
        .clk, .rst, .instrReq, .instrAck, .instr, .wbPort
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic checkBit(input string name, input logic expVal, input logic gotVal);
        if (gotVal !== expVal) begin
            $display("MISMATCH at %0t: %s expected %b got %b", $time, name, expVal, gotVal);
            $display("** FAIL **");
            $fatal(1, "single-bit check failed");
        end
    endtask

    task automatic checkIdx(input string name, input regIdx_t expVal, input regIdx_t gotVal);
        if (gotVal !== expVal) begin
            $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, expVal, gotVal);
            $display("** FAIL **");
            $fatal(1, "register index check failed");
        end
    endtask

    task automatic checkWord(input string name, input word_t expVal, input word_t gotVal);
        if (gotVal !== expVal) begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, expVal, gotVal);
            $display("** FAIL **");
            $fatal(1, "data word check failed");
        end
    endtask

    task automatic stopOnError(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "run stopped on error");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model, one instruction at a time in program order.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic pushWrite(input regIdx_t rd, input word_t value);
        wbPort_t e;
        modelRegs[rd] = value;
        e.valid = 1'b1;
        e.rd    = rd;
        e.value = value;
        expectedQ.push_back(e);
    endtask

    task automatic modelExec(input word_t w);
        regIdx_t   rs;
        regIdx_t   rt;
        regIdx_t   rdR;
        word_t     a;
        word_t     b;
        word_t     immExt;
        word_t     sum;
        dataAddr_t addr;
        rs     = w[10:8];
        rt     = w[7:5];
        rdR    = w[4:2];
        a      = modelRegs[rs];
        b      = modelRegs[rt];
        immExt = {{11{w[4]}}, w[4:0]};
        sum    = a + immExt;
        addr   = sum[MEM_ADDR_W-1:0];
        case (w[15:11])
            OP_ADD:  pushWrite(rdR, a + b);
            OP_SUB:  pushWrite(rdR, a - b);
            OP_AND:  pushWrite(rdR, a & b);
            OP_XOR:  pushWrite(rdR, a ^ b);
            OP_ADDI: pushWrite(rt, sum);
            OP_LD:   pushWrite(rt, modelMem[addr]);
            OP_ST:   modelMem[addr] = b; // no register write, so nothing to expect.
            default: ;
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random instruction builders.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t makeR(input opcode_t op, input regIdx_t rd, input regIdx_t rs,
                                    input regIdx_t rt);
        return {op, rs, rt, rd, 2'b00};
    endfunction

    function automatic word_t makeI(input opcode_t op, input regIdx_t rt, input regIdx_t rs,
                                    input imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t randArith(input regIdx_t rs);
        opcode_t op;
        if (randBelow(3) == 0) begin
            return makeI(OP_ADDI, regIdx_t'(randBelow(8)), rs, imm_t'(randBelow(32)));
        end
        case (randBelow(4))
            0:       op = OP_ADD;
            1:       op = OP_SUB;
            2:       op = OP_AND;
            default: op = OP_XOR;
        endcase
        return makeR(op, regIdx_t'(randBelow(8)), rs, regIdx_t'(randBelow(8)));
    endfunction

    function automatic word_t randUndefined();
        logic [4:0] code;
        code = 5'(randBelow(32));
        // redraw until the code is none of the seven real opcodes.
        while (code inside {5'b11000, 5'b11001, 5'b11010, 5'b11011, 5'b01000,
                            5'b10001, 5'b10000}) begin
            code = 5'(randBelow(32));
        end
        return {code, 11'(randBelow(2048))};
    endfunction

    // four-phase source side. the model runs as the word is offered.
    task automatic sendInstr(input word_t w, input int maxGap);
        int gap;
        gap = randBelow(maxGap + 1);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        instr    <= w;
        instrReq <= 1'b1;
        modelExec(w);
        do @(negedge clk); while (!instrAck);
        @(posedge clk);
        instrReq <= 1'b0;
        do @(negedge clk); while (instrAck); // return to zero before the next word.
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback monitor and watchdog.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!rst && wbPort.valid) begin
            if (expectedQ.size() == 0) begin
                stopOnError("a writeback came out that no instruction should have produced");
            end else begin
                expEntry = expectedQ.pop_front();
                checkIdx("wbPort.rd", expEntry.rd, wbPort.rd);
                checkWord("wbPort.value", expEntry.value, wbPort.value);
            end
        end
    end

    // cycles in which the hazard unit holds the IF slot.
    always @(negedge clk) begin
        if (!rst && dut.stall) begin
            stallCycles <= stallCycles + 1;
        end
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("timeout after %0d cycles with the pipeline still busy", WatchdogCycles);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        regIdx_t prevRd;
        regIdx_t base;
        regIdx_t dataReg;
        imm_t    imm;
        word_t   w;
        int      stallMark;
        seed        = 98;
        stallCycles = 0;
        rst         <= 1'b1;
        instrReq    <= 1'b0;
        instr       <= '0;
        for (int i = 0; i < 8; i++) modelRegs[i] = '0;
        for (int i = 0; i < 2 ** MEM_ADDR_W; i++) modelMem[i] = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // quiet outputs before the first request.
        repeat (5) begin
            @(negedge clk);
            checkBit("instrAck", 1'b0, instrAck);
            checkBit("wbPort.valid", 1'b0, wbPort.valid);
        end

        for (int i = 0; i < 40; i++) sendInstr(randArith(regIdx_t'(randBelow(8))), 0);

        // the producer is still in WB when its consumer reaches the slot.
        prevRd = regIdx_t'(randBelow(8));
        for (int i = 0; i < 30; i++) begin
            w = randArith(prevRd); // reads the register the last one wrote.
            stallMark = stallCycles;
            sendInstr(w, 0);
            if (i > 0 && stallCycles == stallMark) begin
                stopOnError("a dependent instruction left the slot without a register stall");
            end
            prevRd = (w[15:11] == OP_ADDI) ? w[7:5] : w[4:2];
        end

        // store then load through the same base and offset.
        for (int i = 0; i < 20; i++) begin
            base    = regIdx_t'(randBelow(8));
            dataReg = regIdx_t'(randBelow(8));
            imm     = imm_t'(randBelow(4));
            sendInstr(makeI(OP_ST, dataReg, base, imm), 0);
            stallMark = stallCycles;
            sendInstr(makeI(OP_LD, regIdx_t'(randBelow(8)), base, imm), 0);
            if (stallCycles == stallMark) begin
                stopOnError("a load from a pending store address was not stalled");
            end
        end

        for (int i = 0; i < 10; i++) begin
            sendInstr(randUndefined(), 0);
            sendInstr(randArith(regIdx_t'(randBelow(8))), 0);
        end

        for (int i = 0; i < 300; i++) begin
            case (randBelow(8))
                0, 1, 2, 3: w = randArith(regIdx_t'(randBelow(8)));
                4: w = makeI(OP_LD, regIdx_t'(randBelow(8)), regIdx_t'(randBelow(8)),
                             imm_t'(randBelow(4)));
                5, 6: w = makeI(OP_ST, regIdx_t'(randBelow(8)), regIdx_t'(randBelow(8)),
                                imm_t'(randBelow(4)));
                default: w = randUndefined();
            endcase
            sendInstr(w, 4);
        end

        for (int i = 0; i < 60 && expectedQ.size() != 0; i++) @(negedge clk);
        repeat (10) @(negedge clk); // catch any stray writeback.

        if (expectedQ.size() != 0) begin
            $display("%0d expected writebacks never arrived", expectedQ.size());
            $display("** FAIL **");
            $fatal(1, "expected queue not drained");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* verilog.f */
isaPkg.sv
pipePkg.sv
fetchStage.sv
hazardDetect.sv
regFile.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
pipeTop.sv
tb_pipeTop.sv
